// ==== uop_types_pkg.sv ====
package uop_types_pkg;

    // Dispatch lanes per cycle
    localparam int ID_WIDTH = 2;

    typedef logic [5:0] phy_tag_t;
    typedef logic [4:0] rob_id_t;

    // ALU opcodes, fixed encoding shared with the pattern file
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLTU = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9,
        ALU_PASS = 4'd10
    } alu_op_t;

    typedef enum logic {
        OP1_REG  = 1'b0,
        OP1_ZERO = 1'b1
    } op1_sel_t;

    typedef enum logic {
        OP2_REG = 1'b0,
        OP2_IMM = 1'b1
    } op2_sel_t;

    typedef struct packed {
        rob_id_t     rob_id;
        phy_tag_t    rs1_phy;
        phy_tag_t    rs2_phy;
        phy_tag_t    rd_phy;
        op1_sel_t    op1_sel;
        op2_sel_t    op2_sel;
        alu_op_t     fu_opcode;
        logic [31:0] imm;
    } uop_t;

    // One strobe per lane
    typedef struct packed {
        logic [ID_WIDTH-1:0] valid;
        uop_t [ID_WIDTH-1:0] uop;
    } dispatch_t;

endpackage

// ==== exec_types_pkg.sv ====
package exec_types_pkg;

    import uop_types_pkg::*;

    // Station slot contents
    typedef struct packed {
        uop_t uop;
        logic rs1_ready;
        logic rs2_ready;
    } rs_entry_t;

    // Issued op with its operand values
    typedef struct packed {
        rob_id_t     rob_id;
        phy_tag_t    rd_phy;
        op1_sel_t    op1_sel;
        op2_sel_t    op2_sel;
        alu_op_t     fu_opcode;
        logic [31:0] imm;
        logic [31:0] rs1_value;
        logic [31:0] rs2_value;
    } alu_req_t;

    typedef struct packed {
        logic        valid;
        rob_id_t     rob_id;
        phy_tag_t    rd_phy;
        logic [31:0] value;
    } cdb_t;

    // Register preload from the test port
    typedef struct packed {
        logic        valid;
        phy_tag_t    tag;
        logic [31:0] value;
    } prf_init_t;

endpackage

// ==== rs_entry.sv ====
`timescale 1ns/10ps

module rs_entry (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      push,
    input  exec_types_pkg::rs_entry_t entry_in,
    input  logic                      grant,
    input  exec_types_pkg::cdb_t      cdb,
    output logic                      valid,
    output logic                      request,
    output exec_types_pkg::rs_entry_t entry
);

    logic wake1;
    logic wake2;

    // Tag match against the broadcast result
    assign wake1 = valid && cdb.valid && (cdb.rd_phy == entry.uop.rs1_phy);
    assign wake2 = valid && cdb.valid && (cdb.rd_phy == entry.uop.rs2_phy);

    // Occupancy, a granted slot is free at the next edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (push) begin
            valid <= 1'b1;
        end else if (grant) begin
            valid <= 1'b0;
        end
    end

    // Payload and operand ready flags
    always_ff @(posedge clk) begin
        if (push) begin
            entry <= entry_in;
        end else begin
            if (wake1) begin
                entry.rs1_ready <= 1'b1;
            end
            if (wake2) begin
                entry.rs2_ready <= 1'b1;
            end
        end
    end

    // Ask for issue once both sources are in the register file
    assign request = valid && entry.rs1_ready && entry.rs2_ready;

endmodule

// ==== fu_alu.sv ====
`timescale 1ns/10ps

module fu_alu (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req_valid,
    input  exec_types_pkg::alu_req_t req,
    output exec_types_pkg::cdb_t     cdb
);

    import uop_types_pkg::*;
    import exec_types_pkg::*;

    logic        req_valid_q;
    alu_req_t    req_q;
    logic [31:0] op1;
    logic [31:0] op2;
    logic [4:0]  shamt;
    logic [31:0] result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_valid_q <= 1'b0;
        end else begin
            req_valid_q <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        req_q <= req;
    end

    // Operand selection
    assign op1 = (req_q.op1_sel == OP1_ZERO) ? 32'd0 : req_q.rs1_value;
    assign op2 = (req_q.op2_sel == OP2_IMM) ? req_q.imm : req_q.rs2_value;
    assign shamt = op2[4:0];

    always_comb begin
        unique case (req_q.fu_opcode)
            ALU_ADD:  result = op1 + op2;
            ALU_SUB:  result = op1 - op2;
            ALU_AND:  result = op1 & op2;
            ALU_OR:   result = op1 | op2;
            ALU_XOR:  result = op1 ^ op2;
            ALU_SLT:  result = {31'd0, $signed(op1) < $signed(op2)};
            ALU_SLTU: result = {31'd0, op1 < op2};
            ALU_SLL:  result = op1 << shamt;
            ALU_SRL:  result = op1 >> shamt;
            ALU_SRA:  result = $unsigned($signed(op1) >>> shamt);
            ALU_PASS: result = op2;
            default:  result = '0;
        endcase
    end

    // Broadcast
    always_comb begin
        cdb.valid = req_valid_q;
        cdb.rob_id = req_q.rob_id;
        cdb.rd_phy = req_q.rd_phy;
        cdb.value = result;
    end

endmodule

// ==== int_rs.sv ====
`timescale 1ns/10ps

module int_rs #(
    parameter int RS_DEPTH = 8
) (
    input  logic                                                    clk,
    input  logic                                                    rst_n,
    input  uop_types_pkg::dispatch_t                                dispatch,
    output logic                                                    dispatch_ready,
    output uop_types_pkg::phy_tag_t [uop_types_pkg::ID_WIDTH-1:0][1:0] src_tag,
    input  logic [uop_types_pkg::ID_WIDTH-1:0][1:0]                 src_ready,
    output uop_types_pkg::phy_tag_t [uop_types_pkg::ID_WIDTH-1:0]   alloc_tag,
    output logic [uop_types_pkg::ID_WIDTH-1:0]                      alloc_valid,
    output uop_types_pkg::phy_tag_t                                 rd_tag1,
    output uop_types_pkg::phy_tag_t                                 rd_tag2,
    input  logic [31:0]                                             rd_value1,
    input  logic [31:0]                                             rd_value2,
    input  exec_types_pkg::cdb_t                                    cdb,
    output exec_types_pkg::cdb_t                                    cdb_out
);

    import uop_types_pkg::*;
    import exec_types_pkg::*;

    localparam int CNT_W = $clog2(RS_DEPTH + 1);

    logic      [RS_DEPTH-1:0]               rs_valid;
    logic      [RS_DEPTH-1:0]               rs_request;
    logic      [RS_DEPTH-1:0]               rs_grant;
    logic      [RS_DEPTH-1:0]               rs_push;
    logic      [RS_DEPTH-1:0][ID_WIDTH-1:0] push_sel;
    rs_entry_t [RS_DEPTH-1:0]               slot_entry;
    rs_entry_t [RS_DEPTH-1:0]               slot_entry_in;
    rs_entry_t [ID_WIDTH-1:0]               new_entry;
    logic      [ID_WIDTH-1:0]               lane_go;
    logic      [ID_WIDTH-1:0][1:0]          src_hit;
    logic      [CNT_W-1:0]                  free_cnt;
    rs_entry_t                              issued;
    alu_req_t                               alu_req;

    ////////////////////////////////////////////////////////////////////////////
    // Dispatch side
    ////////////////////////////////////////////////////////////////////////////

    assign lane_go = dispatch.valid & {ID_WIDTH{dispatch_ready}};
    assign alloc_valid = lane_go;

    always_comb begin
        for (int w = 0; w < ID_WIDTH; w++) begin
            src_tag[w][0] = dispatch.uop[w].rs1_phy;
            src_tag[w][1] = dispatch.uop[w].rs2_phy;
            alloc_tag[w] = dispatch.uop[w].rd_phy;
        end
    end

    // Initial ready flags from scoreboard or same-cycle CDB hit
    always_comb begin
        for (int w = 0; w < ID_WIDTH; w++) begin
            for (int s = 0; s < 2; s++) begin
                src_hit[w][s] = src_ready[w][s] ||
                                (cdb.valid && cdb.rd_phy == src_tag[w][s]);
                // An older lane in the same group still has to produce it
                for (int p = 0; p < w; p++) begin
                    if (lane_go[p] && dispatch.uop[p].rd_phy == src_tag[w][s]) begin
                        src_hit[w][s] = 1'b0;
                    end
                end
            end
            new_entry[w].uop = dispatch.uop[w];
            new_entry[w].rs1_ready = src_hit[w][0] || (dispatch.uop[w].op1_sel == OP1_ZERO);
            new_entry[w].rs2_ready = src_hit[w][1] || (dispatch.uop[w].op2_sel == OP2_IMM);
        end
    end

    // Each lane takes the first free slot not claimed by an older lane
    always_comb begin : slot_alloc
        logic [RS_DEPTH-1:0] taken;
        logic                placed;
        taken = '0;
        push_sel = '0;
        for (int w = 0; w < ID_WIDTH; w++) begin
            placed = 1'b0;
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (lane_go[w] && !placed && !rs_valid[i] && !taken[i]) begin
                    push_sel[i][w] = 1'b1;
                    taken[i] = 1'b1;
                    placed = 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            rs_push[i] = |push_sel[i];
            slot_entry_in[i] = new_entry[0];
            for (int w = 1; w < ID_WIDTH; w++) begin
                if (push_sel[i][w]) begin
                    slot_entry_in[i] = new_entry[w];
                end
            end
        end
    end

    // Room for a full dispatch group
    always_comb begin
        free_cnt = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (!rs_valid[i]) begin
                free_cnt = free_cnt + CNT_W'(1);
            end
        end
    end
    assign dispatch_ready = (free_cnt >= CNT_W'(ID_WIDTH));

    for (genvar i = 0; i < RS_DEPTH; i++) begin : g_slot
        rs_entry u_slot (
            .clk      (clk),
            .rst_n    (rst_n),
            .push     (rs_push[i]),
            .entry_in (slot_entry_in[i]),
            .grant    (rs_grant[i]),
            .cdb      (cdb),
            .valid    (rs_valid[i]),
            .request  (rs_request[i]),
            .entry    (slot_entry[i])
        );
    end

    ////////////////////////////////////////////////////////////////////////////
    // Issue side
    ////////////////////////////////////////////////////////////////////////////

    // Lowest index wins
    always_comb begin : issue_select
        logic found;
        found = 1'b0;
        rs_grant = '0;
        issued = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (rs_request[i] && !found) begin
                rs_grant[i] = 1'b1;
                issued = slot_entry[i];
                found = 1'b1;
            end
        end
    end

    assign rd_tag1 = issued.uop.rs1_phy;
    assign rd_tag2 = issued.uop.rs2_phy;

    always_comb begin
        alu_req.rob_id = issued.uop.rob_id;
        alu_req.rd_phy = issued.uop.rd_phy;
        alu_req.op1_sel = issued.uop.op1_sel;
        alu_req.op2_sel = issued.uop.op2_sel;
        alu_req.fu_opcode = issued.uop.fu_opcode;
        alu_req.imm = issued.uop.imm;
        alu_req.rs1_value = rd_value1;
        alu_req.rs2_value = rd_value2;
    end

    fu_alu u_alu (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (|rs_grant),
        .req       (alu_req),
        .cdb       (cdb_out)
    );

endmodule

// ==== prf.sv ====
`timescale 1ns/10ps

module prf (
    input  logic                                                    clk,
    input  logic                                                    rst_n,
    input  uop_types_pkg::phy_tag_t [uop_types_pkg::ID_WIDTH-1:0][1:0] src_tag,
    output logic [uop_types_pkg::ID_WIDTH-1:0][1:0]                 src_ready,
    input  uop_types_pkg::phy_tag_t [uop_types_pkg::ID_WIDTH-1:0]   alloc_tag,
    input  logic [uop_types_pkg::ID_WIDTH-1:0]                      alloc_valid,
    input  uop_types_pkg::phy_tag_t                                 rd_tag1,
    input  uop_types_pkg::phy_tag_t                                 rd_tag2,
    output logic [31:0]                                             rd_value1,
    output logic [31:0]                                             rd_value2,
    input  exec_types_pkg::cdb_t                                    cdb,
    input  exec_types_pkg::prf_init_t                               init
);

    import uop_types_pkg::*;

    localparam int NUM_REGS = 1 << $bits(phy_tag_t);

    logic [31:0]         regs [NUM_REGS];
    logic [NUM_REGS-1:0] ready;

    always_ff @(posedge clk) begin
        if (cdb.valid) begin
            regs[cdb.rd_phy] <= cdb.value;
        end
        if (init.valid) begin
            regs[init.tag] <= init.value;
        end
    end

    // Scoreboard, allocation comes last so it beats a same-cycle write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready <= '0;
        end else begin
            if (cdb.valid) begin
                ready[cdb.rd_phy] <= 1'b1;
            end
            if (init.valid) begin
                ready[init.tag] <= 1'b1;
            end
            for (int w = 0; w < ID_WIDTH; w++) begin
                if (alloc_valid[w]) begin
                    ready[alloc_tag[w]] <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        for (int w = 0; w < ID_WIDTH; w++) begin
            for (int s = 0; s < 2; s++) begin
                src_ready[w][s] = ready[src_tag[w][s]];
            end
        end
    end

    assign rd_value1 = regs[rd_tag1];
    assign rd_value2 = regs[rd_tag2];

endmodule

// ==== int_exec_top.sv ====
`timescale 1ns/10ps

module int_exec_top #(
    parameter int RS_DEPTH = 8
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  uop_types_pkg::dispatch_t  dispatch,
    output logic                      dispatch_ready,
    input  exec_types_pkg::prf_init_t prf_init,
    output exec_types_pkg::cdb_t      cdb
);

    import uop_types_pkg::*;

    phy_tag_t [ID_WIDTH-1:0][1:0] src_tag;
    logic     [ID_WIDTH-1:0][1:0] src_ready;
    phy_tag_t [ID_WIDTH-1:0]      alloc_tag;
    logic     [ID_WIDTH-1:0]      alloc_valid;
    phy_tag_t                     rd_tag1;
    phy_tag_t                     rd_tag2;
    logic     [31:0]              rd_value1;
    logic     [31:0]              rd_value2;

    // ALU result loops back as the wakeup bus
    int_rs #(
        .RS_DEPTH (RS_DEPTH)
    ) u_rs (
        .clk            (clk),
        .rst_n          (rst_n),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .src_tag        (src_tag),
        .src_ready      (src_ready),
        .alloc_tag      (alloc_tag),
        .alloc_valid    (alloc_valid),
        .rd_tag1        (rd_tag1),
        .rd_tag2        (rd_tag2),
        .rd_value1      (rd_value1),
        .rd_value2      (rd_value2),
        .cdb            (cdb),
        .cdb_out        (cdb)
    );

    prf u_prf (
        .clk         (clk),
        .rst_n       (rst_n),
        .src_tag     (src_tag),
        .src_ready   (src_ready),
        .alloc_tag   (alloc_tag),
        .alloc_valid (alloc_valid),
        .rd_tag1     (rd_tag1),
        .rd_tag2     (rd_tag2),
        .rd_value1   (rd_value1),
        .rd_value2   (rd_value2),
        .cdb         (cdb),
        .init        (prf_init)
    );

endmodule

// ==== int_exec_properties.sv ====
`timescale 1ns/10ps

module int_exec_properties #(
    parameter int RS_DEPTH = 8
) (
    input logic                clk,
    input logic                rst_n,
    input logic [RS_DEPTH-1:0] rs_grant,
    input logic [RS_DEPTH-1:0] rs_valid,
    input logic [1:0]          dispatch_valid,
    input logic                dispatch_ready,
    input logic                cdb_valid
);

    // At most one slot issues per cycle
    a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(rs_grant))
        else $error("issue grant is not one-hot");

    a_dispatch_when_ready: assert property (@(posedge clk) disable iff (!rst_n)
        (dispatch_valid != 2'b00) |-> dispatch_ready)
        else $error("dispatch strobe while dispatch_ready is low");

    // Nothing on the CDB right after reset release
    a_cdb_idle_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !cdb_valid)
        else $error("cdb valid in the first cycle after reset");

    a_granted_slot_freed: assert property (@(posedge clk) disable iff (!rst_n)
        (rs_grant != '0) |=> ((rs_valid & $past(rs_grant)) == '0))
        else $error("granted slot still valid one cycle later");

endmodule

bind int_rs int_exec_properties #(
    .RS_DEPTH (RS_DEPTH)
) u_props (
    .clk            (clk),
    .rst_n          (rst_n),
    .rs_grant       (rs_grant),
    .rs_valid       (rs_valid),
    .dispatch_valid (dispatch.valid),
    .dispatch_ready (dispatch_ready),
    .cdb_valid      (cdb_out.valid)
);

// ==== int_exec_tb.sv ====
`timescale 1ns/10ps

module int_exec_tb;

    import uop_types_pkg::*;
    import exec_types_pkg::*;

    localparam int RS_DEPTH   = 8;
    localparam int MAX_ROB    = 32;
    localparam int WAIT_LIMIT = 300;

    logic      clk;
    logic      rst_n;
    dispatch_t dispatch;
    logic      dispatch_ready;
    prf_init_t prf_init;
    cdb_t      cdb;

    int          errors = 0;
    int          pattern_errors = 0;
    int          beat_errors = 0;
    int          cycle = 0;
    int          first_strobe_cycle = -1;
    int          first_cdb_cycle = -1;
    int          done_cnt = 0;
    int          ready_low_cycles = 0;
    bit          any_dispatch = 1'b0;
    bit          aborted = 1'b0;

    logic [31:0] model_regs [64];
    uop_t        uops [$];
    logic [31:0] file_exp [$];
    phy_tag_t    pre_tag [$];
    logic [31:0] pre_val [$];
    logic [31:0] exp_val [MAX_ROB];
    phy_tag_t    exp_rd [MAX_ROB];
    bit          issued_rob [MAX_ROB];
    bit          seen [MAX_ROB];

    int_exec_top #(
        .RS_DEPTH (RS_DEPTH)
    ) dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .prf_init       (prf_init),
        .cdb            (cdb)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    ////////////////////////////////////////////////////////////////////////////
    // Reference ALU and pattern handling
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] alu_reference(alu_op_t op, logic [31:0] a, logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_SLL:  return a << sh;
            ALU_SRL:  return a >> sh;
            ALU_SRA:  return $unsigned($signed(a) >>> sh);
            ALU_PASS: return b;
            default:  return 32'd0;
        endcase
    endfunction

    task automatic read_patterns();
        int          fd;
        int          n;
        string       line;
        int          rob;
        int          t1;
        int          t2;
        int          td;
        int          s1;
        int          s2;
        int          op;
        logic [31:0] imm;
        logic [31:0] expv;
        uop_t        u;
        fd = $fopen("int_exec_patterns.txt", "r");
        if (fd == 0) begin
            errors++;
            aborted = 1'b1;
            $display("pattern file int_exec_patterns.txt could not be opened");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 0) begin
                    if (line[0] == "P") begin
                        n = $sscanf(line, "P %h %h", t1, imm);
                        pre_tag.push_back(phy_tag_t'(t1));
                        pre_val.push_back(imm);
                    end else if (line[0] == "U") begin
                        n = $sscanf(line, "U %h %h %h %h %h %h %h %h %h",
                                    rob, t1, t2, td, s1, s2, op, imm, expv);
                        u.rob_id = rob_id_t'(rob);
                        u.rs1_phy = phy_tag_t'(t1);
                        u.rs2_phy = phy_tag_t'(t2);
                        u.rd_phy = phy_tag_t'(td);
                        u.op1_sel = op1_sel_t'(s1[0]);
                        u.op2_sel = op2_sel_t'(s2[0]);
                        u.fu_opcode = alu_op_t'(op[3:0]);
                        u.imm = imm;
                        uops.push_back(u);
                        file_exp.push_back(expv);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Two passes so ops that read a later producer see its value
    task automatic build_expected();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        for (int i = 0; i < 64; i++) begin
            model_regs[i] = 32'd0;
        end
        foreach (pre_tag[i]) begin
            model_regs[pre_tag[i]] = pre_val[i];
        end
        for (int pass = 0; pass < 2; pass++) begin
            foreach (uops[k]) begin
                a = (uops[k].op1_sel == OP1_ZERO) ? 32'd0 : model_regs[uops[k].rs1_phy];
                b = (uops[k].op2_sel == OP2_IMM) ? uops[k].imm : model_regs[uops[k].rs2_phy];
                res = alu_reference(uops[k].fu_opcode, a, b);
                model_regs[uops[k].rd_phy] = res;
                if (pass == 1) begin
                    if (res !== file_exp[k]) begin
                        pattern_errors++;
                        $display("Pattern for rob %0d expects %h but the ALU rules give %h",
                                 uops[k].rob_id, file_exp[k], res);
                    end
                    exp_val[uops[k].rob_id] = file_exp[k];
                    exp_rd[uops[k].rob_id] = uops[k].rd_phy;
                end
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic preload_regs();
        foreach (pre_tag[i]) begin
            @(posedge clk);
            prf_init <= '{valid: 1'b1, tag: pre_tag[i], value: pre_val[i]};
        end
        @(posedge clk);
        prf_init <= '0;
        @(posedge clk);
    endtask

    // Sampled at the falling edge where the status is settled
    task automatic wait_dispatch_ready();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!dispatch_ready && !aborted) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                errors++;
                aborted = 1'b1;
                $display("dispatch_ready stayed low too long, station seems stuck");
            end else begin
                @(negedge clk);
            end
        end
    endtask

    task automatic wait_all_results();
        int waited;
        waited = 0;
        while (done_cnt < uops.size() && !aborted) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                errors++;
                aborted = 1'b1;
                $display("timed out waiting for outstanding CDB results");
            end else begin
                @(posedge clk);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // CDB scoreboard
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_beat();
        int r;
        r = int'(cdb.rob_id);
        if (!issued_rob[r]) begin
            beat_errors++;
            $display("CDB beat at %0t carries rob_id %0d that was never dispatched", $time, r);
        end else if (seen[r]) begin
            beat_errors++;
            $display("rob_id %0d appeared on the CDB a second time at %0t", r, $time);
        end else begin
            seen[r] = 1'b1;
            done_cnt++;
            if (cdb.rd_phy !== exp_rd[r]) begin
                beat_errors++;
                $display("Fail at %0t: cdb.rd_phy for rob %0d got %h expected %h",
                         $time, r, cdb.rd_phy, exp_rd[r]);
            end
            if (cdb.value !== exp_val[r]) begin
                beat_errors++;
                $display("Fail at %0t: cdb.value for rob %0d got %h expected %h",
                         $time, r, cdb.value, exp_val[r]);
            end
        end
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            if (!dispatch_ready) begin
                ready_low_cycles++;
            end
            if (dispatch.valid != 2'b00 && !any_dispatch) begin
                any_dispatch = 1'b1;
                first_strobe_cycle = cycle;
            end
            if (cdb.valid) begin
                if (first_cdb_cycle < 0) begin
                    first_cdb_cycle = cycle;
                    // Lone ready op, strobe to CDB is two cycles
                    if (cycle - first_strobe_cycle != 2) begin
                        beat_errors++;
                        $display("Fail at %0t: cdb.valid latency got %0d expected %0d",
                                 $time, cycle - first_strobe_cycle, 2);
                    end
                end
                check_beat();
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int k;
        int lanes;
        void'($urandom(51658));
        rst_n = 1'b0;
        dispatch = '0;
        prf_init = '0;
        for (int i = 0; i < MAX_ROB; i++) begin
            issued_rob[i] = 1'b0;
            seen[i] = 1'b0;
            exp_val[i] = 32'd0;
            exp_rd[i] = '0;
        end
        read_patterns();
        build_expected();
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        preload_regs();

        k = 0;
        while (k < uops.size() && !aborted) begin
            if (k > 0 && ($urandom % 8) == 0) begin
                @(posedge clk);
            end
            wait_dispatch_ready();
            if (!aborted) begin
                lanes = 2;
                if (k == 0 || k == uops.size() - 1 || ($urandom % 8) == 0) begin
                    lanes = 1;
                end
                @(posedge clk);
                dispatch.valid <= (lanes == 2) ? 2'b11 : 2'b01;
                dispatch.uop[0] <= uops[k];
                issued_rob[uops[k].rob_id] = 1'b1;
                if (lanes == 2) begin
                    dispatch.uop[1] <= uops[k + 1];
                    issued_rob[uops[k + 1].rob_id] = 1'b1;
                end
                k += lanes;
                @(posedge clk);
                dispatch.valid <= 2'b00;
            end
        end

        wait_all_results();
        if (!aborted) begin
            // Room for stray beats to show up
            repeat (10) @(posedge clk);
            if (ready_low_cycles == 0) begin
                errors++;
                $display("dispatch_ready never dropped although the station was filled");
            end
        end

        $display("Errors: %0d check, %0d beat, %0d pattern", errors, beat_errors, pattern_errors);
        if (errors == 0 && beat_errors == 0 && pattern_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
uop_types_pkg.sv
exec_types_pkg.sv
rs_entry.sv
fu_alu.sv
int_rs.sv
prf.sv
int_exec_top.sv
int_exec_properties.sv
int_exec_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/10ps
TOP       ?= int_exec_tb
FILELIST  ?= list.f
LOG       ?= sim.log
OBJDIR    ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	grep -q "Everything OK" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/10ps -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== int_exec_patterns.txt ====
# P tag value | U rob rs1 rs2 rd op1_sel op2_sel opcode imm expected, all hex
# opcodes 0 add 1 sub 2 and 3 or 4 xor 5 slt 6 sltu 7 sll 8 srl 9 sra a pass
P 01 00000064
P 02 fffffff6
P 03 00000005
P 04 80000000
U 00 01 02 10 0 0 0 00000000 0000005a
U 01 02 01 11 0 0 1 00000000 ffffff92
U 02 02 01 12 0 0 5 00000000 00000001
U 03 02 01 13 0 0 6 00000000 00000000
U 04 04 03 14 0 0 9 00000000 fc000000
U 05 00 00 15 1 1 a 12345678 12345678
U 06 30 01 20 0 0 0 00000000 000001c8
U 07 30 03 21 0 0 1 00000000 0000015f
U 08 30 00 22 0 1 2 000000f0 00000060
U 09 30 00 23 0 1 8 00000022 00000059
U 0a 30 03 24 0 0 7 00000000 00002c80
U 0b 30 02 25 0 0 4 00000000 fffffe92
U 0c 01 00 30 0 1 0 00000100 00000164
U 0d 20 04 26 0 0 3 00000000 800001c8
U 0e 26 03 27 0 0 9 00000000 fc00000e
U 0f 27 02 28 0 0 5 00000000 00000001
U 10 27 01 29 0 0 6 00000000 00000000
U 11 28 29 2a 0 0 0 00000000 00000001
U 12 00 2a 2b 1 0 a 00000000 00000001
U 13 00 2b 2c 1 0 1 00000000 ffffffff
U 14 2c 21 2d 0 0 2 00000000 0000015f
U 15 2d 2a 2e 0 0 0 00000000 00000160
